// File: ahbLite.sv
`timescale 1ns/1ns

module ahbLite
    import ahbLitePkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 10,          // 4 KiB
    parameter int GPIO_WIDTH     = 16
)
(
    input  logic                  HCLK,
    input  logic                  rstN,

    // Master side
    input  addrT                  hAddr,
    input  transT                 hTrans,
    input  logic                  hWrite,
    input  sizeT                  hSize,
    input  dataT                  hWData,
    output logic                  hReady,
    output logic                  hResp,
    output dataT                  hRData,

    // Peripheral pins
    input  logic [GPIO_WIDTH-1:0] gpioIn,
    output logic [GPIO_WIDTH-1:0] gpioOut,
    output logic [GPIO_WIDTH-1:0] gpioOe,
    output logic                  irq           // Timer interrupt
);

    selT                   hSel;
    logic [NUM_SLAVES-1:0] hReadyOutVec;
    logic [NUM_SLAVES-1:0] hRespVec;
    dataT [NUM_SLAVES-1:0] hRDataVec;

    // Decoder and mux
    // ------------------------------------------------------------------------
    ahbLiteDecoder uDecoder (
        .hAddr        (hAddr),
        .hSel         (hSel)
    );

    ahbLiteSlaveMux uSlaveMux (
        .HCLK         (HCLK),
        .rstN         (rstN),
        .hReady       (hReady),                 // Own output fed back
        .hTrans       (hTrans),
        .hSel         (hSel),
        .hReadyOutVec (hReadyOutVec),
        .hRespVec     (hRespVec),
        .hRDataVec    (hRDataVec),
        .hReadyOut    (hReady),
        .hRespOut     (hResp),
        .hRDataOut    (hRData)
    );

    // RAM
    // ------------------------------------------------------------------------
    ahbLiteBlockRAM #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) uRAM (
        .HCLK         (HCLK),
        .rstN         (rstN),
        .hSel         (hSel[SLV_RAM]),
        .hAddr        (hAddr),
        .hTrans       (hTrans),
        .hWrite       (hWrite),
        .hSize        (hSize),
        .hWData       (hWData),
        .hReady       (hReady),
        .hReadyOut    (hReadyOutVec[SLV_RAM]),
        .hResp        (hRespVec[SLV_RAM]),
        .hRData       (hRDataVec[SLV_RAM])
    );

    // GPIO
    // ------------------------------------------------------------------------
    ahbLiteGPIO #(.GPIO_WIDTH(GPIO_WIDTH)) uGPIO (
        .HCLK         (HCLK),
        .rstN         (rstN),
        .hSel         (hSel[SLV_GPIO]),
        .hAddr        (hAddr),
        .hTrans       (hTrans),
        .hWrite       (hWrite),
        .hSize        (hSize),
        .hWData       (hWData),
        .hReady       (hReady),
        .hReadyOut    (hReadyOutVec[SLV_GPIO]),
        .hResp        (hRespVec[SLV_GPIO]),
        .hRData       (hRDataVec[SLV_GPIO]),
        .gpioIn       (gpioIn),
        .gpioOut      (gpioOut),
        .gpioOe       (gpioOe)
    );

    // Timer
    // ------------------------------------------------------------------------
    ahbLiteTimer uTimer (
        .HCLK         (HCLK),
        .rstN         (rstN),
        .hSel         (hSel[SLV_TIMER]),
        .hAddr        (hAddr),
        .hTrans       (hTrans),
        .hWrite       (hWrite),
        .hSize        (hSize),
        .hWData       (hWData),
        .hReady       (hReady),
        .hReadyOut    (hReadyOutVec[SLV_TIMER]),
        .hResp        (hRespVec[SLV_TIMER]),
        .hRData       (hRDataVec[SLV_TIMER]),
        .irq          (irq)
    );

endmodule

// File: ahbLiteBlockRAM.sv
`timescale 1ns/1ns

module ahbLiteBlockRAM
    import ahbLitePkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 10           // Word address bits
)
(
    input  logic  HCLK,
    input  logic  rstN,
    input  logic  hSel,
    input  addrT  hAddr,
    input  transT hTrans,
    input  logic  hWrite,
    input  sizeT  hSize,
    input  dataT  hWData,
    input  logic  hReady,
    output logic  hReadyOut,
    output logic  hResp,
    output dataT  hRData
);

    typedef enum logic {RAM_IDLE, RAM_WAIT} ramStateT;

    ramStateT                  state;
    logic                      accept;
    logic                      wrPend;          // Write data phase in progress
    logic [RAM_ADDR_WIDTH-1:0] dAddr;           // Registered word address
    logic [1:0]                dLow;            // Registered byte offset
    sizeT                      dSize;
    logic [3:0]                lanes;
    dataT                      mem [2**RAM_ADDR_WIDTH];

    assign accept    = hSel && hReady && isActive(hTrans);
    assign hReadyOut = (state == RAM_IDLE);     // Low for the read wait state
    assign hResp     = 1'b0;

    // Control
    // ------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            wrPend <= 1'b0;
            state  <= RAM_IDLE;
        end else begin
            wrPend <= accept && hWrite;
            state  <= (accept && !hWrite) ? RAM_WAIT : RAM_IDLE;
        end
    end

    // Byte lanes from size and offset
    always_comb begin
        case (dSize)
            SIZE_BYTE: lanes = 4'b0001 << dLow;
            SIZE_HALF: lanes = dLow[1] ? 4'b1100 : 4'b0011;
            default:   lanes = 4'b1111;
        endcase
    end

    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (accept) begin
            dAddr <= hAddr[RAM_ADDR_WIDTH+1:2];
            dLow  <= hAddr[1:0];
            dSize <= hSize;
        end
        if (wrPend) begin                       // Commit at end of data phase
            for (int i = 0; i < 4; i++) begin
                if (lanes[i]) begin
                    mem[dAddr][i*8 +: 8] <= hWData[i*8 +: 8];
                end
            end
        end
        if (state == RAM_WAIT) begin            // Sees a write from the cycle before
            hRData <= mem[dAddr];
        end
    end

    // Master must align halfword and word accesses
    assert property (@(posedge HCLK) disable iff (!rstN)
        accept |-> !((hSize == SIZE_HALF) && hAddr[0])
                && !((hSize == SIZE_WORD) && (hAddr[1:0] != 2'b00)));

endmodule

// File: ahbLiteDecoder.sv
`timescale 1ns/1ns

module ahbLiteDecoder
    import ahbLitePkg::*;
(
    input  addrT hAddr,                         // Address phase address
    output selT  hSel                           // At most one bit set
);

    // Independent region compares, so overlap in the map shows up below
    always_comb begin
        hSel[SLV_RAM]   = (hAddr[31:28] == RAM_BASE_TAG);   // Low 256 MiB, aliased
        hSel[SLV_GPIO]  = (hAddr[31:12] == GPIO_PAGE);      // One 4 KiB page
        hSel[SLV_TIMER] = (hAddr[31:12] == TIMER_PAGE);
        assert ($onehot0(hSel))
            else $error("Decoder regions overlap at address %h", hAddr);
    end

endmodule

// File: ahbLiteGPIO.sv
`timescale 1ns/1ns

module ahbLiteGPIO
    import ahbLitePkg::*;
#(
    parameter int GPIO_WIDTH = 16               // Pin count
)
(
    input  logic                  HCLK,
    input  logic                  rstN,
    input  logic                  hSel,
    input  addrT                  hAddr,
    input  transT                 hTrans,
    input  logic                  hWrite,
    input  sizeT                  hSize,
    input  dataT                  hWData,
    input  logic                  hReady,
    output logic                  hReadyOut,
    output logic                  hResp,
    output dataT                  hRData,
    input  logic [GPIO_WIDTH-1:0] gpioIn,       // Asynchronous pins
    output logic [GPIO_WIDTH-1:0] gpioOut,
    output logic [GPIO_WIDTH-1:0] gpioOe        // 1 drives the pin
);

    logic                  accept;
    logic                  wrPend;
    logic [11:0]           dOffset;             // Register offset, data phase
    logic [GPIO_WIDTH-1:0] syncA;
    logic [GPIO_WIDTH-1:0] syncB;               // Safe to read

    assign accept    = hSel && hReady && isActive(hTrans);
    assign hReadyOut = 1'b1;                    // Never waits
    assign hResp     = 1'b0;

    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            wrPend  <= 1'b0;
            gpioOut <= '0;
            gpioOe  <= '0;
        end else begin
            wrPend <= accept && hWrite;
            if (wrPend && (dOffset == REG_GPIO_OUT)) begin
                gpioOut <= hWData[GPIO_WIDTH-1:0];
            end
            if (wrPend && (dOffset == REG_GPIO_DIR)) begin
                gpioOe <= hWData[GPIO_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            dOffset <= hAddr[11:0];
        end
        syncA <= gpioIn;                        // Two-flop synchronizer
        syncB <= syncA;
    end

    // Read back, zero-extended
    always_comb begin
        hRData = '0;
        case (dOffset)
            REG_GPIO_OUT: hRData[GPIO_WIDTH-1:0] = gpioOut;
            REG_GPIO_DIR: hRData[GPIO_WIDTH-1:0] = gpioOe;
            REG_GPIO_IN:  hRData[GPIO_WIDTH-1:0] = syncB;
            default:      ;
        endcase
    end

    // Word registers only
    assert property (@(posedge HCLK) disable iff (!rstN)
        accept |-> (hSize == SIZE_WORD));

endmodule

// File: ahbLitePkg.sv
package ahbLitePkg;

    // Bus types
    // ------------------------------------------------------------------------
    typedef logic [31:0] addrT;                 // Byte address
    typedef logic [31:0] dataT;                 // One bus word
    typedef logic [1:0]  transT;                // HTRANS code
    typedef logic [2:0]  sizeT;                 // HSIZE code

    localparam transT TRANS_IDLE   = 2'b00;
    localparam transT TRANS_BUSY   = 2'b01;
    localparam transT TRANS_NONSEQ = 2'b10;
    localparam transT TRANS_SEQ    = 2'b11;

    localparam sizeT SIZE_BYTE = 3'b000;
    localparam sizeT SIZE_HALF = 3'b001;
    localparam sizeT SIZE_WORD = 3'b010;

    // Slaves and memory map
    // ------------------------------------------------------------------------
    localparam int NUM_SLAVES = 3;
    localparam int SLV_RAM    = 0;              // Also the bit in select vectors
    localparam int SLV_GPIO   = 1;
    localparam int SLV_TIMER  = 2;

    typedef logic [NUM_SLAVES-1:0] selT;        // One-hot slave select

    localparam logic [3:0]  RAM_BASE_TAG = 4'h0;        // Compared with hAddr[31:28]
    localparam logic [19:0] GPIO_PAGE    = 20'h40000;   // Compared with hAddr[31:12]
    localparam logic [19:0] TIMER_PAGE   = 20'h40001;

    localparam logic [11:0] REG_GPIO_OUT   = 12'h000;
    localparam logic [11:0] REG_GPIO_DIR   = 12'h004;
    localparam logic [11:0] REG_GPIO_IN    = 12'h008;
    localparam logic [11:0] REG_TMR_LOAD   = 12'h000;
    localparam logic [11:0] REG_TMR_VALUE  = 12'h004;
    localparam logic [11:0] REG_TMR_CTRL   = 12'h008;
    localparam logic [11:0] REG_TMR_STATUS = 12'h00C;

    // NONSEQ or SEQ, a real transfer
    function automatic logic isActive(transT trans);
        return (trans == TRANS_NONSEQ) || (trans == TRANS_SEQ);
    endfunction

endpackage

// File: ahbLiteSlaveMux.sv
`timescale 1ns/1ns

module ahbLiteSlaveMux
    import ahbLitePkg::*;
(
    input  logic                  HCLK,
    input  logic                  rstN,
    input  logic                  hReady,       // Global ready, fed back
    input  transT                 hTrans,
    input  selT                   hSel,         // From decoder, address phase
    input  logic [NUM_SLAVES-1:0] hReadyOutVec,
    input  logic [NUM_SLAVES-1:0] hRespVec,
    input  dataT [NUM_SLAVES-1:0] hRDataVec,
    output logic                  hReadyOut,
    output logic                  hRespOut,
    output dataT                  hRDataOut
);

    typedef enum logic {ERR_FIRST, ERR_SECOND} errStateT;

    selT      dataSel;                          // Select of current data phase
    logic     unmapped;                         // Active transfer hit no slave
    errStateT errState;

    // Data-phase capture
    // ------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            dataSel  <= '0;
            unmapped <= 1'b0;
        end else if (hReady) begin              // Address phase accepted
            dataSel  <= hSel;
            unmapped <= (hSel == '0) && isActive(hTrans);
        end
    end

    // Default slave, two-cycle ERROR
    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            errState <= ERR_FIRST;
        end else if (unmapped) begin
            errState <= (errState == ERR_FIRST) ? ERR_SECOND : ERR_FIRST;
        end
    end

    // Response mux
    // ------------------------------------------------------------------------
    always_comb begin
        hReadyOut = 1'b1;                       // Idle or unselected, zero wait OKAY
        hRespOut  = 1'b0;
        hRDataOut = '0;
        if (unmapped) begin
            hReadyOut = (errState == ERR_SECOND);
            hRespOut  = 1'b1;
        end else begin
            for (int i = 0; i < NUM_SLAVES; i++) begin
                if (dataSel[i]) begin
                    hReadyOut = hReadyOutVec[i];
                    hRespOut  = hRespVec[i];
                    hRDataOut = hRDataVec[i];
                end
            end
        end
    end

    // Completing ERROR cycle must follow a waited ERROR cycle
    assert property (@(posedge HCLK) disable iff (!rstN)
        (hRespOut && hReadyOut) |-> $past(hRespOut && !hReadyOut));

endmodule

// File: ahbLiteTimer.sv
`timescale 1ns/1ns

module ahbLiteTimer
    import ahbLitePkg::*;
(
    input  logic  HCLK,
    input  logic  rstN,
    input  logic  hSel,
    input  addrT  hAddr,
    input  transT hTrans,
    input  logic  hWrite,
    input  sizeT  hSize,
    input  dataT  hWData,
    input  logic  hReady,
    output logic  hReadyOut,
    output logic  hResp,
    output dataT  hRData,
    output logic  irq
);

    logic        accept;
    logic        wrPend;                        // Word write in data phase
    logic [11:0] dOffset;
    dataT        loadReg;
    dataT        valueReg;                      // Read-only count
    logic [1:0]  ctrlReg;                       // Bit 0 enable, bit 1 irq enable
    logic        pending;
    logic        underflow;

    assign accept    = hSel && hReady && isActive(hTrans);
    assign underflow = ctrlReg[0] && (valueReg == '0);
    assign hReadyOut = 1'b1;
    assign hResp     = 1'b0;
    assign irq       = pending && ctrlReg[1];

    always_ff @(posedge HCLK) begin
        wrPend <= rstN && accept && hWrite && (hSize == SIZE_WORD);  // Narrow writes dropped
        if (accept) begin
            dOffset <= hAddr[11:0];
        end
    end

    // Counter and registers
    // ------------------------------------------------------------------------
    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            loadReg  <= '0;
            valueReg <= '0;
            ctrlReg  <= '0;
            pending  <= 1'b0;
        end else begin
            if (underflow) begin                // Reload and flag
                valueReg <= loadReg;
                pending  <= 1'b1;
            end else if (ctrlReg[0]) begin
                valueReg <= valueReg - 1'b1;
            end
            if (wrPend) begin
                case (dOffset)
                    REG_TMR_LOAD: begin         // Restarts the count too
                        loadReg  <= hWData;
                        valueReg <= hWData;
                    end
                    REG_TMR_CTRL:   ctrlReg <= hWData[1:0];
                    REG_TMR_STATUS: begin
                        if (hWData[0] && !underflow) begin
                            pending <= 1'b0;    // Write 1 to clear, new event wins
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (dOffset)
            REG_TMR_LOAD:   hRData = loadReg;
            REG_TMR_VALUE:  hRData = valueReg;
            REG_TMR_CTRL:   hRData = {30'b0, ctrlReg};
            REG_TMR_STATUS: hRData = {31'b0, pending};
            default:        hRData = '0;
        endcase
    end

    // Count stays within the reload range
    assert property (@(posedge HCLK) disable iff (!rstN)
        ctrlReg[0] |-> (valueReg <= loadReg));

endmodule

// File: ahbTests.txt
# cmd addr(hex) data(hex) size(0 byte, 1 half, 2 word) resp(1 ERROR)
# W write, R read vs data, M RAM read vs model, B burst of data pairs, O E Q pin vs data, I gpioIn, P poll
# RAM byte lanes
W 00000010 11223344 2 0
M 00000010 00000000 2 0
W 00000012 AABB0000 1 0
M 00000010 00000000 2 0
W 00000011 0000CC00 0 0
M 00000010 00000000 2 0
W 00000020 0000005A 0 0
W 00000023 7E000000 0 0
M 00000020 00000000 2 0
W 00000024 CAFEF00D 2 0
W 00000024 00001234 1 0
M 00000024 00000000 2 0
B 00000100 00000040 0 0
# GPIO
W 40000000 FFFFA5C3 2 0
W 40000004 0000FF0F 2 0
O 00000000 0000A5C3 0 0
E 00000000 0000FF0F 0 0
R 40000000 0000A5C3 2 0
R 40000004 0000FF0F 2 0
I 00000000 00003C96 0 0
R 40000008 00003C96 2 0
# Timer
W 40001000 00000014 2 0
R 40001000 00000014 2 0
W 40001008 00000003 2 0
R 40001008 00000003 2 0
P 4000100C 00000001 0 0
Q 00000000 00000001 0 0
W 4000100C 00000001 2 0
Q 00000000 00000000 0 0
W 40001008 00000000 2 0
R 4000100C 00000000 2 0
# Unmapped
W 50000000 DEADBEEF 2 1
R 40000000 0000A5C3 2 0
R 40002000 00000000 2 1
M 00000010 00000000 2 0
R 80000010 00000000 2 1
R 40000004 0000FF0F 2 0

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the passing line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tbAHBLite -f tb.f -o simAHBLite &&
./obj_dir/simAHBLite | tee /dev/stderr | grep -qx '>>> PASS' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: tb.f
ahbLitePkg.sv
ahbLiteDecoder.sv
ahbLiteSlaveMux.sv
ahbLiteBlockRAM.sv
ahbLiteGPIO.sv
ahbLiteTimer.sv
ahbLite.sv
tbClock.sv
tbAHBLite.sv

// File: tbAHBLite.sv
`timescale 1ns/1ns

module tbAHBLite
    import ahbLitePkg::*;
();

    localparam int RAM_ADDR_WIDTH = 10;
    localparam int GPIO_WIDTH     = 16;
    localparam int RAM_BYTES      = 4 << RAM_ADDR_WIDTH;
    localparam int WAIT_LIMIT     = 16;         // hReady low cycles per transfer
    localparam int RESET_LIMIT    = 32;
    localparam int POLL_LIMIT     = 100;

    logic                  HCLK;
    logic                  rstN;
    addrT                  hAddr;
    transT                 hTrans;
    logic                  hWrite;
    sizeT                  hSize;
    dataT                  hWData;
    logic                  hReady;
    logic                  hResp;
    dataT                  hRData;
    logic [GPIO_WIDTH-1:0] gpioIn;
    logic [GPIO_WIDTH-1:0] gpioOut;
    logic [GPIO_WIDTH-1:0] gpioOe;
    logic                  irq;

    // Transfer now in its data phase
    logic dpValid;
    logic dpWrite;
    addrT dpAddr;
    dataT dpWData;
    logic dpResp;                               // Expected hResp
    int   dpWaits;                              // Expected wait states
    dataT dpExp;
    dataT dpMask;                               // Read bits worth comparing
    dataT lastRData;

    logic [7:0] ramModel [RAM_BYTES];           // Scoreboard with one entry per byte
    bit         ramKnown [RAM_BYTES];
    int         checks;
    int         errors;

    tbClock #(.PERIOD(40), .RESET_CYCLES(8)) uClock (.HCLK(HCLK), .rstN(rstN));

    ahbLite #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH), .GPIO_WIDTH(GPIO_WIDTH)) ahbLite_i (.*);

    // Checks and bus driver
    // ------------------------------------------------------------------------
    task automatic checkValue(input string what, input dataT got, input dataT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic abortRun(input string why);
        $display("Run stopped at %0t ns: %s", $time, why);
        $display("Checks %0d, errors %0d", checks, errors);
        $display(">>> FAIL");
        $finish;
    endtask

    function automatic logic inRam(input addrT a);
        return a[31:28] == RAM_BASE_TAG;
    endfunction

    // New address phase overlapping the data phase of the one before
    task automatic issue(input logic act, input addrT a, input logic wr, input sizeT sz,
                         input dataT wd, input logic resp, input dataT exp, input dataT mask);
        int waits;
        waits   = 0;
        hTrans <= act ? TRANS_NONSEQ : TRANS_IDLE;
        hAddr  <= a;
        hWrite <= wr;
        hSize  <= sz;
        hWData <= dpWData;                      // Belongs to the older transfer
        @(negedge HCLK);
        while (!hReady) begin                   // Address phase held meanwhile
            waits++;
            if (waits > WAIT_LIMIT) abortRun($sformatf("hReady stuck low at %h", dpAddr));
            @(negedge HCLK);
        end
        if (dpValid) begin
            checkValue($sformatf("hResp at %h", dpAddr), dataT'(hResp), dataT'(dpResp));
            checkValue($sformatf("wait states at %h", dpAddr), dataT'(waits), dataT'(dpWaits));
            if (!dpWrite) lastRData = hRData;
            if (!dpWrite && !dpResp && (dpMask != '0)) begin
                checkValue($sformatf("read at %h", dpAddr), hRData & dpMask, dpExp & dpMask);
            end
        end
        @(posedge HCLK);                        // Address phase taken here
        dpValid = act;
        dpWrite = wr;
        dpAddr  = a;
        dpWData = wd;
        dpResp  = resp;
        dpExp   = exp;
        dpMask  = mask;
        dpWaits = (resp || (act && !wr && inRam(a))) ? 1 : 0;  // ERROR or RAM read
    endtask

    task automatic drain();
        issue(1'b0, '0, 1'b0, SIZE_WORD, '0, 1'b0, '0, '0);
    endtask

    task automatic maybeIdle();
        if (($urandom % 4) == 0) drain();
    endtask

    // RAM scoreboard
    // ------------------------------------------------------------------------
    task automatic ramWrite(input addrT a, input dataT d, input sizeT sz);
        int   base;
        int   i;
        logic lane;
        base = int'(a % RAM_BYTES) & ~3;        // RAM repeats over its region
        for (i = 0; i < 4; i++) begin
            lane = (sz == SIZE_WORD) || ((sz == SIZE_HALF) && (i[1] == a[1]))
                || ((sz == SIZE_BYTE) && (i[1:0] == a[1:0]));
            if (lane) begin                     // Lane i carries bits i*8 up
                ramModel[base + i] = d[i*8 +: 8];
                ramKnown[base + i] = 1'b1;
            end
        end
        issue(1'b1, a, 1'b1, sz, d, 1'b0, '0, '0);
    endtask

    task automatic ramRead(input addrT a);
        int   base;
        int   i;
        dataT exp;
        dataT mask;
        base = int'(a % RAM_BYTES) & ~3;
        exp  = '0;
        mask = '0;
        for (i = 0; i < 4; i++) begin
            if (ramKnown[base + i]) begin       // Never written bytes skipped
                exp[i*8 +: 8]  = ramModel[base + i];
                mask[i*8 +: 8] = 8'hFF;
            end
        end
        issue(1'b1, {a[31:2], 2'b00}, 1'b0, SIZE_WORD, '0, 1'b0, exp, mask);
    endtask

    // Write and read pairs mostly back to back
    task automatic runBurst(input addrT base, input int pairs);
        addrT a;
        sizeT sz;
        int   n;
        for (n = 0; n < pairs; n++) begin
            sz = sizeT'($urandom % 3);
            a  = base + (($urandom % 64) << 2);
            if (sz == SIZE_HALF) a[1] = ($urandom % 2) == 1;
            if (sz == SIZE_BYTE) a[1:0] = 2'($urandom % 4);
            maybeIdle();
            ramWrite(a, $urandom, sz);
            ramRead(a);
        end
    endtask

    task automatic pollUntil(input addrT a, input dataT mask);
        int polls;
        polls     = 0;
        lastRData = '0;
        while ((lastRData & mask) == '0) begin
            if (polls == POLL_LIMIT) abortRun($sformatf("bits %h at %h never set", mask, a));
            issue(1'b1, a, 1'b0, SIZE_WORD, '0, 1'b0, '0, '0);
            drain();                            // Completes the read
            polls++;
        end
    endtask

    // One line of the test file
    task automatic runCommand(input logic [7:0] cmd, input addrT a, input dataT d,
                              input sizeT sz, input logic resp);
        case (cmd)
            "W": begin
                maybeIdle();
                if (inRam(a)) ramWrite(a, d, sz);
                else issue(1'b1, a, 1'b1, sz, d, resp, '0, '0);
            end
            "R": begin
                maybeIdle();
                issue(1'b1, a, 1'b0, sz, '0, resp, d, '1);
            end
            "M": begin
                maybeIdle();
                ramRead(a);
            end
            "B": runBurst(a, int'(d));
            "P": pollUntil(a, d);
            "I": begin
                gpioIn <= d[GPIO_WIDTH-1:0];
                repeat (2) drain();             // Two synchronizer stages
            end
            "O", "E", "Q": begin
                drain();                        // Last write committed
                @(negedge HCLK);
                case (cmd)
                    "O":     checkValue("gpioOut", dataT'(gpioOut), d);
                    "E":     checkValue("gpioOe", dataT'(gpioOe), d);
                    default: checkValue("irq", dataT'(irq), d);
                endcase
                @(posedge HCLK);
            end
            default: begin
                errors++;
                $display("Unknown command '%c' in the test file", cmd);
            end
        endcase
    endtask

    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int         fd;
        int         n;
        int         tries;
        int         sz;
        int         resp;
        string      line;
        logic [7:0] cmd;
        addrT       a;
        dataT       d;
        hAddr     = '0;
        hTrans    = TRANS_IDLE;
        hWrite    = 1'b0;
        hSize     = SIZE_WORD;
        hWData    = '0;
        gpioIn    = '0;
        dpValid   = 1'b0;
        dpWData   = '0;
        lastRData = '0;
        checks    = 0;
        errors    = 0;
        void'($urandom(32'h7eab));
        tries = 0;
        while (rstN !== 1'b1) begin
            if (tries > RESET_LIMIT) abortRun("reset never released");
            @(posedge HCLK);
            tries++;
        end
        @(negedge HCLK);
        checkValue("reset hReady", dataT'(hReady), 32'd1);
        checkValue("reset hResp", dataT'(hResp), 32'd0);
        checkValue("reset irq", dataT'(irq), 32'd0);
        checkValue("reset gpioOut", dataT'(gpioOut), 32'd0);
        checkValue("reset gpioOe", dataT'(gpioOe), 32'd0);
        @(posedge HCLK);
        fd = $fopen("ahbTests.txt", "r");
        if (fd == 0) abortRun("cannot open ahbTests.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0) continue;
            n = $sscanf(line, "%c %h %h %d %d", cmd, a, d, sz, resp);
            if ((n != 5) || (cmd == "#")) continue;   // Comments and blank lines
            runCommand(cmd, a, d, sizeT'(sz), resp[0]);
        end
        $fclose(fd);
        drain();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tbClock.sv
`timescale 1ns/1ns

module tbClock #(
    parameter int PERIOD       = 40,            // ns
    parameter int RESET_CYCLES = 8
)
(
    output logic HCLK,
    output logic rstN
);

    initial begin
        HCLK = 1'b0;
        forever #(PERIOD/2) HCLK = ~HCLK;
    end

    initial begin
        rstN = 1'b0;                            // Low from time zero
        repeat (RESET_CYCLES) @(posedge HCLK);
        rstN <= 1'b1;
    end

endmodule
